// File: dv/rca_tb.sv
`default_nettype none

module rca_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rca_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int NUM_TESTS  = 5;
    localparam logic [31:0] B_CONST = 32'h1234_5677;

    // ready_mode: 0 always ready, 1 held low until op_ready drops, 2 random
    typedef struct packed {
        logic       cfg_b;
        int         n_ops;
        logic       rand_valid;
        logic [1:0] ready_mode;
    } test_row_t;

    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{1'b0, 8, 1'b0, 2'd0},
        '{1'b1, 8, 1'b0, 2'd0},
        '{1'b0, 8, 1'b0, 2'd1},
        '{1'b0, 6, 1'b1, 2'd0},
        '{1'b0, 40, 1'b1, 2'd2}
    };

    // {address, data} pairs
    localparam logic [36:0] CFG_A [11] = '{
        {5'd1, 32'd1}, {5'd2, 32'd2}, {5'd3, 32'd2}, {5'd6, 32'd1}, {5'd7, 32'd1},
        {5'd16, 32'd1}, {5'd17, 32'd1}, {5'd18, 32'd1},
        {5'd21, 32'd3}, {5'd22, 32'd1}, {5'd24, 32'd3}
    };
    // unit 1 is a stalled queue holding the constant, so its valid stays high
    localparam logic [36:0] CFG_B [14] = '{
        {5'd9, B_CONST}, {5'd1, 32'd4}, {5'd5, 32'd1}, {5'd2, 32'd3}, {5'd3, 32'd3},
        {5'd6, 32'd1}, {5'd7, 32'd1}, {5'd16, 32'd1}, {5'd13, 32'd3}, {5'd21, 32'd5},
        {5'd15, 32'd1}, {5'd19, 32'd2}, {5'd23, 32'd4}, {5'd24, 32'd3}
    };

    logic                                clk;
    logic                                arst_n;
    logic                                op_valid;
    operand_t                            op_data;
    logic                                op_ready;
    logic                                cfg_we;
    logic [CFG_ADDR_W-1:0]               cfg_addr;
    logic [XLEN-1:0]                     cfg_data;
    logic [NUM_IO_UNITS-1:0]             res_valid;
    logic [NUM_IO_UNITS-1:0][XLEN-1:0]   res_data;
    logic [NUM_IO_UNITS-1:0]             res_ready;

    logic [31:0] lfsr_state;
    logic [31:0] exp_q [NUM_IO_UNITS][$];
    int          errors;
    int          total_errors;
    int          failed_tests;

    rca_top #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_rca_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_valid  (op_valid),
        .op_data   (op_data),
        .op_ready  (op_ready),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_ready (res_ready)
    );

    always #50 clk = ~clk;

    function automatic string test_name(input int idx);
        case (idx)
            0:       return "config A";
            1:       return "config B";
            2:       return "back-pressure";
            3:       return "stream mode";
            default: return "random traffic";
        endcase
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // expected results from the routing of each configuration
    function automatic logic [31:0] model_unit2(input logic cfg_b, input logic [31:0] a,
                                                input logic [31:0] b);
        return cfg_b ? a + B_CONST : a + b;
    endfunction

    function automatic logic [31:0] model_unit3(input logic cfg_b, input logic [31:0] a,
                                                input logic [31:0] b);
        logic [31:0] sum;
        if (cfg_b) begin
            sum = a + B_CONST;
            return sum * B_CONST;
        end
        sum = a + b;
        return sum - (a ^ b);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_unit(input int u, input logic fire);
        if (fire) begin
            assert (exp_q[u].size() != 0) else begin
                $display("unit %0d returned a result with none expected at %0t ns", u, $time);
                errors++;
            end
            if (exp_q[u].size() != 0) begin
                check_value($sformatf("res_data[%0d]", u), exp_q[u].pop_front(), res_data[u]);
            end
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #10;
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #10;
        arst_n = 1'b1;
    endtask

    task automatic apply_config(input logic cfg_b);
        int n;
        n = cfg_b ? 14 : 11;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #10;
            cfg_we   = 1'b1;
            cfg_addr = cfg_b ? CFG_B[i][36:32] : CFG_A[i][36:32];
            cfg_data = cfg_b ? CFG_B[i][31:0] : CFG_A[i][31:0];
        end
        @(posedge clk);
        #10;
        cfg_we = 1'b0;
    endtask

    task automatic run_test(input int idx);
        test_row_t   row;
        int          accepted;
        int          cycles;
        int          limit;
        int          low_cycles;
        logic        pending;
        logic        hold;
        logic [31:0] v;
        logic [31:0] a;
        logic [31:0] b;
        row        = TESTS[idx];
        errors     = 0;
        accepted   = 0;
        cycles     = 0;
        low_cycles = 0;
        pending    = 1'b0;
        hold       = (row.ready_mode == 2'd1);
        limit      = row.n_ops * 30 + 200;
        for (int u = 0; u < NUM_IO_UNITS; u++) exp_q[u].delete();
        reset_dut();
        apply_config(row.cfg_b);
        while ((accepted < row.n_ops || exp_q[0].size() != 0 || exp_q[1].size() != 0 ||
                exp_q[2].size() != 0 || exp_q[3].size() != 0) && cycles < limit) begin
            @(posedge clk);
            #10;
            cycles++;
            if (!pending) begin
                op_valid = 1'b0;
                if (accepted < row.n_ops) begin
                    take_bits(1, v);
                    if (!row.rand_valid || v[0]) begin
                        take_bits(32, a);
                        take_bits(32, b);
                        op_data.a = a;
                        op_data.b = b;
                        op_valid  = 1'b1;
                        pending   = 1'b1;
                    end
                end
            end
            take_bits(1, v);
            res_ready[0] = v[0];
            res_ready[1] = !row.cfg_b;
            take_bits(1, v);
            case (row.ready_mode)
                2'd1:    res_ready[3:2] = hold ? 2'b00 : 2'b11;
                2'd2:    res_ready[3:2] = {v[0], v[0]};
                default: res_ready[3:2] = 2'b11;
            endcase
            @(negedge clk);
            if (op_valid && op_ready) begin
                exp_q[0].push_back(op_data.a);
                if (!row.cfg_b) exp_q[1].push_back(op_data.b);
                exp_q[2].push_back(model_unit2(row.cfg_b, op_data.a, op_data.b));
                exp_q[3].push_back(model_unit3(row.cfg_b, op_data.a, op_data.b));
                accepted++;
                pending = 1'b0;
            end
            if (hold) begin
                low_cycles = op_ready ? 0 : low_cycles + 1;
                if (low_cycles == 3) begin
                    check_value("accepts before op_ready low", FIFO_DEPTH, accepted);
                    hold = 1'b0;
                end
            end
            // stream units ignore res_ready
            check_unit(0, res_valid[0]);
            if (row.cfg_b) begin
                // unit 1 holds the constant at its queue head
                if (res_valid[1]) check_value("res_data[1]", B_CONST, res_data[1]);
            end else begin
                check_unit(1, res_valid[1]);
            end
            check_unit(2, res_valid[2] && res_ready[2]);
            check_unit(3, res_valid[3] && res_ready[3]);
        end
        if (cycles >= limit) begin
            $display("test %0d timed out with %0d of %0d operations accepted",
                     idx + 1, accepted, row.n_ops);
            errors++;
        end
        @(posedge clk);
        #10;
        op_valid  = 1'b0;
        res_ready = '0;
        $display("test %0d %s: %0d operations, %0d errors", idx + 1, test_name(idx),
                 accepted, errors);
        if (errors != 0) failed_tests++;
        total_errors += errors;
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        op_valid     = 1'b0;
        op_data      = '0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_data     = '0;
        res_ready    = '0;
        lfsr_state   = 32'h24f3;
        total_errors = 0;
        failed_tests = 0;

        errors = 0;
        reset_dut();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value("op_ready", 32'd1, {31'd0, op_ready});
            check_value("res_valid", 32'd0, {28'd0, res_valid});
        end
        $display("test 0 reset: %0d errors", errors);
        if (errors != 0) failed_tests++;
        total_errors += errors;

        for (int t = 0; t < NUM_TESTS; t++) run_test(t);

        $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS + 1, failed_tests,
                 total_errors);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/rca_top_props.sv
`default_nettype none

module rca_top_props #(
    parameter int FIFO_DEPTH = 4
) (
    input logic                                                clk,
    input logic                                                arst_n,
    input logic                                                op_valid,
    input rca_pkg::operand_t                                   op_data,
    input logic                                                op_ready,
    input logic                                                cfg_we,
    input logic [$clog2(FIFO_DEPTH+1)-1:0]                     outstanding,
    input rca_pkg::grid_cfg_t                                  cfg,
    input logic [rca_pkg::NUM_IO_UNITS-1:0]                    res_valid,
    input logic [rca_pkg::NUM_IO_UNITS-1:0]                    res_ready,
    input logic [rca_pkg::NUM_IO_UNITS-1:0][rca_pkg::XLEN-1:0] res_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import rca_pkg::*;

    count_limit: assert property (@(posedge clk) disable iff (!arst_n)
        int'(outstanding) <= FIFO_DEPTH)
        else $error("outstanding count above FIFO depth");

    // a stalled operand stays offered and unchanged until it is taken
    stall_holds_operand: assert property (@(posedge clk) disable iff (!arst_n)
        (op_valid && !op_ready) |=> (op_valid && $stable(op_data)))
        else $error("operand changed or dropped while op_ready low");

    cfg_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        cfg_we |-> (outstanding == '0))
        else $error("configuration write with results outstanding");

    // queue head must hold while stalled
    for (genvar k = 0; k < NUM_IO_UNITS; k++) begin : g_stable
        head_stable: assert property (@(posedge clk) disable iff (!arst_n)
            (cfg.io[k].mode == MODE_QUEUE && res_valid[k] && !res_ready[k])
            |=> $stable(res_data[k]))
            else $error("queue unit %0d changed res_data while stalled", k);
    end

endmodule

bind rca_top rca_top_props #(
    .FIFO_DEPTH(FIFO_DEPTH)
) i_top_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .op_valid    (op_valid),
    .op_data     (op_data),
    .op_ready    (op_ready),
    .cfg_we      (cfg_we),
    .outstanding (i_flow_ctrl.outstanding),
    .cfg         (cfg),
    .res_valid   (res_valid),
    .res_ready   (res_ready),
    .res_data    (res_data)
);

`default_nettype wire

// File: hw/rca_cfg_regs.sv
`default_nettype none

module rca_cfg_regs (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            cfg_we,
    input  logic [rca_pkg::CFG_ADDR_W-1:0]  cfg_addr,
    input  logic [rca_pkg::XLEN-1:0]        cfg_data,
    output rca_pkg::grid_cfg_t              cfg
);
    import rca_pkg::*;

    typedef enum logic [2:0] {
        FLD_NONE,
        FLD_IO_SEL,
        FLD_IO_MODE,
        FLD_CONST,
        FLD_SEL1,
        FLD_SEL2,
        FLD_OP,
        FLD_DRAIN
    } cfg_field_e;

    cfg_field_e            field;
    logic [CFG_ADDR_W-1:0] offset;
    logic [UNIT_IDX_W-1:0] unit_idx;
    logic [SLOT_IDX_W-1:0] slot_idx;

    // address range decode, offset is relative to the field base
    always_comb begin
        field  = FLD_NONE;
        offset = '0;
        if (cfg_addr < CFG_IO_MODE_BASE) begin
            field  = FLD_IO_SEL;
            offset = cfg_addr - CFG_IO_SEL_BASE;
        end else if (cfg_addr < CFG_CONST_BASE) begin
            field  = FLD_IO_MODE;
            offset = cfg_addr - CFG_IO_MODE_BASE;
        end else if (cfg_addr < CFG_SEL1_BASE) begin
            field  = FLD_CONST;
            offset = cfg_addr - CFG_CONST_BASE;
        end else if (cfg_addr < CFG_SEL2_BASE) begin
            field  = FLD_SEL1;
            offset = cfg_addr - CFG_SEL1_BASE;
        end else if (cfg_addr < CFG_OP_BASE) begin
            field  = FLD_SEL2;
            offset = cfg_addr - CFG_SEL2_BASE;
        end else if (cfg_addr < CFG_DRAIN_ADDR) begin
            field  = FLD_OP;
            offset = cfg_addr - CFG_OP_BASE;
        end else if (cfg_addr == CFG_DRAIN_ADDR) begin
            field  = FLD_DRAIN;
        end
    end

    assign unit_idx = offset[UNIT_IDX_W-1:0];
    assign slot_idx = offset[SLOT_IDX_W-1:0];

    // write data is truncated to the field width
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg <= '0;
        end else if (cfg_we) begin
            case (field)
                FLD_IO_SEL:  cfg.io[unit_idx].sel      <= cfg_data[IO_SEL_W-1:0];
                FLD_IO_MODE: cfg.io[unit_idx].mode     <= io_mode_e'(cfg_data[0]);
                FLD_CONST:   cfg.io[unit_idx].constant <= cfg_data;
                FLD_SEL1:    cfg.slot[slot_idx].sel1   <= cfg_data[GRID_SEL_W-1:0];
                FLD_SEL2:    cfg.slot[slot_idx].sel2   <= cfg_data[GRID_SEL_W-1:0];
                FLD_OP:      cfg.slot[slot_idx].op     <= slot_op_e'(cfg_data[2:0]);
                FLD_DRAIN:   cfg.drain_unit            <= cfg_data[UNIT_IDX_W-1:0];
                default:     ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/rca_flow_ctrl.sv
`default_nettype none

module rca_flow_ctrl #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             op_accept,
    input  logic [rca_pkg::NUM_IO_UNITS-1:0] res_valid,
    input  logic [rca_pkg::NUM_IO_UNITS-1:0] res_ready,
    input  rca_pkg::grid_cfg_t               cfg,
    output logic                             op_ready
);
    import rca_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [CNT_W-1:0] outstanding;
    logic             drain_pop;

    // only a queue unit returns credits
    assign drain_pop = (cfg.io[cfg.drain_unit].mode == MODE_QUEUE) &&
                       res_valid[cfg.drain_unit] && res_ready[cfg.drain_unit];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= '0;
        end else begin
            case ({op_accept, drain_pop})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= (outstanding != '0) ? outstanding - 1'b1 : '0;
                default: outstanding <= outstanding;
            endcase
        end
    end

    assign op_ready = (outstanding != CNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: hw/rca_io_unit.sv
`default_nettype none

module rca_io_unit #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic [rca_pkg::IO_MUX_INPUTS-1:0][rca_pkg::XLEN-1:0] mux_data,
    input  logic [rca_pkg::IO_MUX_INPUTS-1:0]                    mux_valid,
    input  rca_pkg::io_cfg_t                                     cfg,
    output logic                                                 out_valid,
    output logic [rca_pkg::XLEN-1:0]                             out_data,
    input  logic                                                 pop
);
    import rca_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [XLEN-1:0]  sel_data;
    logic             sel_valid;
    logic             is_queue;
    logic             stream_valid;
    logic [XLEN-1:0]  stream_data;
    logic [XLEN-1:0]  fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_count;
    logic             fifo_full;
    logic             push;
    logic             pop_fire;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // input crossbar, unused select codes give an idle input
    always_comb begin
        sel_data  = '0;
        sel_valid = 1'b0;
        if (cfg.sel < IO_SEL_W'(IO_MUX_INPUTS)) begin
            sel_data  = mux_data[cfg.sel];
            sel_valid = mux_valid[cfg.sel];
        end
    end

    assign is_queue  = (cfg.mode == MODE_QUEUE);
    assign fifo_full = (fifo_count == CNT_W'(FIFO_DEPTH));
    assign pop_fire  = is_queue && pop && (fifo_count != '0);
    assign push      = is_queue && sel_valid && (!fifo_full || pop_fire);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stream_valid <= 1'b0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fifo_count   <= '0;
        end else begin
            stream_valid <= sel_valid && !is_queue;
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop_fire) rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop_fire})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        stream_data <= sel_data;
        if (push) fifo_mem[wr_ptr] <= sel_data;
    end

    // queue presents the head entry, stream the last registered word
    assign out_valid = is_queue ? (fifo_count != '0) : stream_valid;
    assign out_data  = is_queue ? fifo_mem[rd_ptr] : stream_data;

endmodule

`default_nettype wire

// File: hw/rca_pkg.sv
`default_nettype none

package rca_pkg;

    localparam int XLEN            = 32;
    localparam int NUM_READ_PORTS  = 2;
    localparam int GRID_ROWS       = 2;
    localparam int GRID_COLS       = 2;
    localparam int NUM_SLOTS       = GRID_ROWS * GRID_COLS;
    // units 0 and 1 are ingress, unit k >= 2 reads row k-2
    localparam int NUM_IO_UNITS    = GRID_ROWS + 2;
    localparam int IO_MUX_INPUTS   = NUM_READ_PORTS + GRID_COLS + 1;
    localparam int GRID_MUX_INPUTS = GRID_COLS + 2;

    localparam int IO_SEL_W   = $clog2(IO_MUX_INPUTS);
    localparam int GRID_SEL_W = $clog2(GRID_MUX_INPUTS);
    localparam int UNIT_IDX_W = $clog2(NUM_IO_UNITS);
    localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);
    localparam int CFG_ADDR_W = 5;

    // configuration address map, one block of addresses per field
    localparam logic [CFG_ADDR_W-1:0] CFG_IO_SEL_BASE  = '0;
    localparam logic [CFG_ADDR_W-1:0] CFG_IO_MODE_BASE = CFG_IO_SEL_BASE + CFG_ADDR_W'(NUM_IO_UNITS);
    localparam logic [CFG_ADDR_W-1:0] CFG_CONST_BASE   = CFG_IO_MODE_BASE + CFG_ADDR_W'(NUM_IO_UNITS);
    localparam logic [CFG_ADDR_W-1:0] CFG_SEL1_BASE    = CFG_CONST_BASE + CFG_ADDR_W'(NUM_IO_UNITS);
    localparam logic [CFG_ADDR_W-1:0] CFG_SEL2_BASE    = CFG_SEL1_BASE + CFG_ADDR_W'(NUM_SLOTS);
    localparam logic [CFG_ADDR_W-1:0] CFG_OP_BASE      = CFG_SEL2_BASE + CFG_ADDR_W'(NUM_SLOTS);
    localparam logic [CFG_ADDR_W-1:0] CFG_DRAIN_ADDR   = CFG_OP_BASE + CFG_ADDR_W'(NUM_SLOTS);

    typedef enum logic [2:0] {
        OP_ADD    = 3'd0,
        OP_SUB    = 3'd1,
        OP_AND    = 3'd2,
        OP_XOR    = 3'd3,
        OP_MUL_LO = 3'd4,
        OP_PASS_A = 3'd5
    } slot_op_e;

    typedef enum logic {
        MODE_STREAM = 1'b0,
        MODE_QUEUE  = 1'b1
    } io_mode_e;

    typedef struct packed {
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } operand_t;

    typedef struct packed {
        logic [GRID_SEL_W-1:0] sel1;
        logic [GRID_SEL_W-1:0] sel2;
        slot_op_e              op;
    } slot_cfg_t;

    typedef struct packed {
        logic [IO_SEL_W-1:0] sel;
        io_mode_e            mode;
        logic [XLEN-1:0]     constant;
    } io_cfg_t;

    // slot index is row * GRID_COLS + col
    typedef struct packed {
        io_cfg_t   [NUM_IO_UNITS-1:0] io;
        slot_cfg_t [NUM_SLOTS-1:0]    slot;
        logic      [UNIT_IDX_W-1:0]   drain_unit;
    } grid_cfg_t;

endpackage

`default_nettype wire

// File: hw/rca_pr_grid.sv
`default_nettype none

module rca_pr_grid #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                                clk,
    input  logic                                                arst_n,
    input  logic                                                op_valid_acc,
    input  rca_pkg::operand_t                                   op_data,
    input  rca_pkg::grid_cfg_t                                  cfg,
    output logic [rca_pkg::NUM_IO_UNITS-1:0]                    res_valid,
    output logic [rca_pkg::NUM_IO_UNITS-1:0][rca_pkg::XLEN-1:0] res_data,
    input  logic [rca_pkg::NUM_IO_UNITS-1:0]                    res_ready
);
    import rca_pkg::*;

    logic [NUM_READ_PORTS-1:0][XLEN-1:0] rs_vals;

    logic [NUM_IO_UNITS-1:0][IO_MUX_INPUTS-1:0][XLEN-1:0] io_mux_data;
    logic [NUM_IO_UNITS-1:0][IO_MUX_INPUTS-1:0]           io_mux_valid;

    logic [GRID_ROWS-1:0][GRID_COLS-1:0][GRID_MUX_INPUTS-1:0][XLEN-1:0] slot_mux_data;
    logic [GRID_ROWS-1:0][GRID_COLS-1:0][GRID_MUX_INPUTS-1:0]           slot_mux_valid;

    logic [GRID_ROWS-1:0][GRID_COLS-1:0][XLEN-1:0] slot_data;
    logic [GRID_ROWS-1:0][GRID_COLS-1:0]           slot_valid;

    // operand word 0 is a, word 1 is b
    assign rs_vals = {op_data.b, op_data.a};

    for (genvar k = 0; k < NUM_IO_UNITS; k++) begin : g_io
        for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_port
            assign io_mux_data[k][p]  = rs_vals[p];
            assign io_mux_valid[k][p] = op_valid_acc;
        end
        for (genvar c = 0; c < GRID_COLS; c++) begin : g_row_in
            if (k < 2) begin : g_none
                // ingress units have no row above them
                assign io_mux_data[k][NUM_READ_PORTS+c]  = '0;
                assign io_mux_valid[k][NUM_READ_PORTS+c] = 1'b0;
            end else begin : g_row
                assign io_mux_data[k][NUM_READ_PORTS+c]  = slot_data[k-2][c];
                assign io_mux_valid[k][NUM_READ_PORTS+c] = slot_valid[k-2][c];
            end
        end
        assign io_mux_data[k][IO_MUX_INPUTS-1]  = cfg.io[k].constant;
        assign io_mux_valid[k][IO_MUX_INPUTS-1] = op_valid_acc;

        rca_io_unit #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) i_io_unit (
            .clk       (clk),
            .arst_n    (arst_n),
            .mux_data  (io_mux_data[k]),
            .mux_valid (io_mux_valid[k]),
            .cfg       (cfg.io[k]),
            .out_valid (res_valid[k]),
            .out_data  (res_data[k]),
            .pop       (res_ready[k])
        );
    end

    for (genvar r = 0; r < GRID_ROWS; r++) begin : g_row
        for (genvar c = 0; c < GRID_COLS; c++) begin : g_col
            for (genvar n = 0; n < GRID_COLS; n++) begin : g_above
                if (r == 0) begin : g_ingress
                    assign slot_mux_data[r][c][n]  = res_data[n];
                    assign slot_mux_valid[r][c][n] = res_valid[n];
                end else begin : g_slot
                    assign slot_mux_data[r][c][n]  = slot_data[r-1][n];
                    assign slot_mux_valid[r][c][n] = slot_valid[r-1][n];
                end
            end
            assign slot_mux_data[r][c][GRID_MUX_INPUTS-2]  = res_data[r];
            assign slot_mux_valid[r][c][GRID_MUX_INPUTS-2] = res_valid[r];
            if (c == 0) begin : g_no_left
                assign slot_mux_data[r][c][GRID_MUX_INPUTS-1]  = '0;
                assign slot_mux_valid[r][c][GRID_MUX_INPUTS-1] = 1'b0;
            end else begin : g_left
                assign slot_mux_data[r][c][GRID_MUX_INPUTS-1]  = slot_data[r][c-1];
                assign slot_mux_valid[r][c][GRID_MUX_INPUTS-1] = slot_valid[r][c-1];
            end

            rca_pr_slot i_slot (
                .clk       (clk),
                .arst_n    (arst_n),
                .mux_data  (slot_mux_data[r][c]),
                .mux_valid (slot_mux_valid[r][c]),
                .cfg       (cfg.slot[r*GRID_COLS+c]),
                .out_valid (slot_valid[r][c]),
                .out_data  (slot_data[r][c])
            );
        end
    end

endmodule

`default_nettype wire

// File: hw/rca_pr_slot.sv
`default_nettype none

module rca_pr_slot (
    input  logic                                                   clk,
    input  logic                                                   arst_n,
    input  logic [rca_pkg::GRID_MUX_INPUTS-1:0][rca_pkg::XLEN-1:0] mux_data,
    input  logic [rca_pkg::GRID_MUX_INPUTS-1:0]                    mux_valid,
    input  rca_pkg::slot_cfg_t                                     cfg,
    output logic                                                   out_valid,
    output logic [rca_pkg::XLEN-1:0]                               out_data
);
    import rca_pkg::*;

    logic [XLEN-1:0] in1;
    logic [XLEN-1:0] in2;
    logic            in1_valid;
    logic            in2_valid;
    logic [XLEN-1:0] alu_result;
    logic            alu_valid;

    // two independent crossbars
    assign in1       = mux_data[cfg.sel1];
    assign in1_valid = mux_valid[cfg.sel1];
    assign in2       = mux_data[cfg.sel2];
    assign in2_valid = mux_valid[cfg.sel2];

    always_comb begin
        alu_valid = in1_valid && in2_valid;
        case (cfg.op)
            OP_ADD:    alu_result = in1 + in2;
            OP_SUB:    alu_result = in1 - in2;
            OP_AND:    alu_result = in1 & in2;
            OP_XOR:    alu_result = in1 ^ in2;
            // product truncated to the low XLEN bits
            OP_MUL_LO: alu_result = in1 * in2;
            OP_PASS_A: begin
                alu_result = in1;
                alu_valid  = in1_valid;
            end
            default:   alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= alu_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_data <= alu_result;
    end

endmodule

`default_nettype wire

// File: hw/rca_top.sv
`default_nettype none

module rca_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                                clk,
    input  logic                                                arst_n,
    // operand channel
    input  logic                                                op_valid,
    input  rca_pkg::operand_t                                   op_data,
    output logic                                                op_ready,
    // configuration write
    input  logic                                                cfg_we,
    input  logic [rca_pkg::CFG_ADDR_W-1:0]                      cfg_addr,
    input  logic [rca_pkg::XLEN-1:0]                            cfg_data,
    // results, one channel per I/O unit
    output logic [rca_pkg::NUM_IO_UNITS-1:0]                    res_valid,
    output logic [rca_pkg::NUM_IO_UNITS-1:0][rca_pkg::XLEN-1:0] res_data,
    input  logic [rca_pkg::NUM_IO_UNITS-1:0]                    res_ready
);
    import rca_pkg::*;

    grid_cfg_t cfg;
    logic      op_accept;

    assign op_accept = op_valid && op_ready;

    rca_cfg_regs i_cfg_regs (
        .clk      (clk),
        .arst_n   (arst_n),
        .cfg_we   (cfg_we),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .cfg      (cfg)
    );

    rca_flow_ctrl #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_flow_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_accept (op_accept),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .cfg       (cfg),
        .op_ready  (op_ready)
    );

    rca_pr_grid #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_pr_grid (
        .clk          (clk),
        .arst_n       (arst_n),
        .op_valid_acc (op_accept),
        .op_data      (op_data),
        .cfg          (cfg),
        .res_valid    (res_valid),
        .res_data     (res_data),
        .res_ready    (res_ready)
    );

endmodule

`default_nettype wire

// File: list.f
hw/rca_pkg.sv
hw/rca_cfg_regs.sv
hw/rca_io_unit.sv
hw/rca_pr_slot.sv
hw/rca_pr_grid.sv
hw/rca_flow_ctrl.sv
hw/rca_top.sv
dv/rca_top_props.sv
dv/rca_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module rca_tb -o rca_sim

./obj_dir/rca_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    exit 1
fi
